// File: bench/geodesics_input.txt
48 32 0 0 0 0 0 001f 0 3
2 60 0 0 0 0 0 0000 0 1
36 32 0 0 0 0 0 ffff 0 1
64 13 0 0 0 0 0 f800 0 1
62 11 0 0 0 0 0 0000 0 1
66 48 0 0 0 0 0 f800 0 1
48 32 48 32 1 0 0 fda0 0 1
69 31 69 31 1 0 0 fda0 0 1
70 31 70 31 1 0 0 fda0 0 1
71 31 71 31 1 0 0 fda0 0 1
69 32 69 32 1 0 0 fda0 0 1
70 32 70 32 1 0 0 fda0 0 1
71 32 71 32 1 0 0 fda0 0 1
69 33 69 33 1 0 0 fda0 0 1
70 33 70 33 1 0 0 fda0 0 1
71 33 71 33 1 0 0 fda0 0 1
69 34 69 34 1 0 0 fda0 0 1
70 34 70 34 1 0 0 fda0 0 1
69 31 69 31 1 0 0 fda0 0 1
2 60 70 34 1 0 0 0000 0 1
2 60 70 34 1 0 0 0000 12 3
48 32 0 0 0 0 0 f81e 0 1
70 32 0 0 0 0 0 f800 0 1
71 34 0 0 0 0 0 f800 0 1
36 32 0 0 0 0 2 ffff 11 7
64 13 0 0 0 0 2 f800 11 7
2 60 0 0 0 0 2 0000 0 0
2 60 0 0 0 0 2 0000 0 0
2 60 0 0 0 0 2 0000 0 0
0 0 0 0 0 0 0 0000 0 10
2 60 0 0 0 1 0 0000 0 1
57 5 0 0 0 0 0 f800 0 1
66 54 0 0 0 0 0 f800 0 1
64 13 0 0 0 0 0 001f 0 3
61 7 0 0 0 0 0 0000 0 1
40 32 40 32 1 0 0 fda0 0 1
41 32 41 32 1 0 0 fda0 0 1
42 32 42 32 1 0 0 fda0 0 1
2 60 42 32 1 0 0 0000 0 1
2 60 42 32 1 0 0 0000 0 1
40 32 0 0 0 0 1 f81e 3 b
36 32 0 0 0 0 1 ffff 3 b
2 60 0 0 0 0 1 0000 0 0
2 60 0 0 0 0 1 0000 0 0
2 60 0 0 0 0 1 0000 0 0

// File: bench/geodesics_tb.sv
`timescale 1ns/1ps
`include "geodesics_consts.svh"

module geodesics_tb;
    import geodesics_pkg::*;

    // One stimulus row with its expected responses
    typedef struct packed {
        xcoord_t    x;
        ycoord_t    y;
        xcoord_t    mouse_x;
        ycoord_t    mouse_y;
        logic       mouse_l;
        logic       new_round;
        logic [1:0] display_sel;
        color_t     color;
        count_t     led;
        logic [7:0] mode;
    } row_t;

    logic         clock;
    logic         reset;
    xcoord_t      x;
    ycoord_t      y;
    xcoord_t      mouse_x;
    ycoord_t      mouse_y;
    logic         mouse_l;
    logic         new_round;
    display_sel_t display_sel;
    color_t       pixel_data;
    count_t       led;
    logic         correct;
    logic         incorrect;
    logic         ready;

    row_t rows[$];
    row_t pending[$];
    int   watchdog_cycles = 0;

    geodesics_top dut (
        .clock       (clock),
        .reset       (reset),
        .x           (x),
        .y           (y),
        .mouse_x     (mouse_x),
        .mouse_y     (mouse_y),
        .mouse_l     (mouse_l),
        .new_round   (new_round),
        .display_sel (display_sel),
        .pixel_data  (pixel_data),
        .led         (led),
        .correct     (correct),
        .incorrect   (incorrect),
        .ready       (ready)
    );

    always #2 clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("** Error at %0.1f ns: %s expected 0x%0h, got 0x%0h",
                     $realtime, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic drive_row(input row_t r);
        x           = r.x;
        y           = r.y;
        mouse_x     = r.mouse_x;
        mouse_y     = r.mouse_y;
        mouse_l     = r.mouse_l;
        new_round   = r.new_round;
        display_sel = display_sel_t'(r.display_sel);
    endtask

    // Bit 0 of mode checks the color, bit 1 led, bit 2 correct, bit 3 incorrect
    task automatic check_row(input row_t r);
        if (r.mode[0]) begin
            check_value("pixel_data", r.color, pixel_data);
        end
        if (r.mode[1]) begin
            check_value("led", r.led, led);
        end
        if (r.mode[2] || r.mode[3]) begin
            check_value("correct", r.mode[2], correct);
            check_value("incorrect", r.mode[3], incorrect);
        end
    endtask

    task automatic apply_reset();
        int cycles;
        drive_row('0);
        reset = 1'b1;
        repeat (4) @(posedge clock);
        #0.5;
        reset = 1'b0;
        check_value("ready", 0, ready);
        // Screen stays black during the memory clear sweep
        cycles = 0;
        while (!ready) begin
            @(posedge clock);
            #0.5;
            cycles++;
            check_value("pixel_data", `COLOR_BLACK, pixel_data);
        end
        check_value("ready delay", `PIXEL_COUNT, cycles);
        check_value("led", 0, led);
        check_value("correct", 0, correct);
        check_value("incorrect", 0, incorrect);
    endtask

    task automatic load_rows();
        int   fd;
        int   code;
        int   v[10];
        row_t r;
        fd = $fopen("bench/geodesics_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/geodesics_input.txt");
            $display("Simulation failed");
            $fatal(1);
        end else begin
            code = 10;
            while (code == 10) begin
                code = $fscanf(fd, "%d %d %d %d %d %d %d %h %d %h\n",
                               v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                if (code == 10) begin
                    r = {7'(v[0]), 6'(v[1]), 7'(v[2]), 6'(v[3]), 1'(v[4]), 1'(v[5]),
                         2'(v[6]), 16'(v[7]), 11'(v[8]), 8'(v[9])};
                    rows.push_back(r);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int sweeps;
        clock = 1'b0;
        reset = 1'b1;
        drive_row('0);
        load_rows();
        sweeps = 1;
        foreach (rows[i]) begin
            if (rows[i].mode == 8'h10) begin
                sweeps++;
            end
        end
        watchdog_cycles = sweeps * (`PIXEL_COUNT + 8) + 4 * rows.size() + 100;
        apply_reset();
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clock);
            #0.5;
            // Pixel of a row is out two cycles after its sampling edge
            if (pending.size() == 3) begin
                check_row(pending.pop_front());
            end
            // Mode 10 reruns the reset and the sweep
            if (rows[i].mode == 8'h10) begin
                pending.delete();
                apply_reset();
            end else begin
                drive_row(rows[i]);
                pending.push_back(rows[i]);
            end
        end
        $display("Simulation passed");
        $finish;
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

// File: geodesics.f
+incdir+include
source/geodesics_pkg.sv
source/puzzle_generator.sv
source/sphere_geometry.sv
source/trace_overlay.sv
source/answer_scorer.sv
source/geodesics_top.sv
bench/geodesics_tb.sv

// File: include/geodesics_consts.svh
`ifndef GEODESICS_CONSTS_SVH
`define GEODESICS_CONSTS_SVH

// Screen
`define SCREEN_W        96
`define SCREEN_H        64
`define PIXEL_COUNT     (`SCREEN_W * `SCREEN_H)

// Sphere drawn as a disk
`define CENTER_X        48
`define CENTER_Y        32
`define SPHERE_R        32

// Fixed great circles
`define RING_MAJOR      31
`define RING_MINOR      12

// Puzzle offsets added to the LFSR values
`define RING_BASE       17
`define POINT_HIGH_OFS  5
`define POINT_LOW_OFS   42
`define MARKER_MIN_ROW  4

// LFSR seeds, none of them the all-ones lock-up state
`define SEED_RING       4'h5
`define SEED_SIDE       4'h3
`define SEED_HIGH       4'h8
`define SEED_LOW        4'h6

// RGB565 colors
`define COLOR_BLACK     16'b00000_000000_00000
`define COLOR_BLUE      16'b00000_000000_11111
`define COLOR_WHITE     16'b11111_111111_11111
`define COLOR_PURPLE    16'b11111_000000_11110
`define COLOR_RED       16'b11111_000000_00000
`define COLOR_ORANGE    16'b11111_101101_00000

// Verdict
`define OVERLAP_MIN     9
`define OFF_MAX         128

`endif

// File: run.sh
#!/usr/bin/env bash
# Build and run the geodesics testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module geodesics_tb -Mdir obj_dir -o geodesics_sim \
    -f geodesics.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/geodesics_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "No pass line found in sim.log"
    exit 1
fi
exit 0

// File: source/answer_scorer.sv
`timescale 1ns/1ps
`include "geodesics_consts.svh"

module answer_scorer (
    input  logic                        clock,
    input  logic                        reset,
    input  geodesics_pkg::overlay_t     overlay,
    input  logic                        mouse_l,
    input  geodesics_pkg::display_sel_t display_sel,
    output geodesics_pkg::count_t       led,
    output logic                        correct,
    output logic                        incorrect
);
    import geodesics_pkg::*;

    count_t drawn;
    count_t overlap;
    count_t off;
    logic   pass;

    // Counters stop at full scale
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            drawn   <= '0;
            overlap <= '0;
        end else begin
            if (overlay.new_trace && (drawn != '1)) begin
                drawn <= drawn + 1'b1;
            end
            if (overlay.new_overlap && (overlap != '1)) begin
                overlap <= overlap + 1'b1;
            end
        end
    end

    assign off  = drawn - overlap;
    assign pass = (overlap > count_t'(`OVERLAP_MIN)) && (off < count_t'(`OFF_MAX));

    always_comb begin
        case (display_sel)
            SHOW_DRAWN:   led = drawn;
            SHOW_OFF:     led = off;
            SHOW_OVERLAP: led = overlap;
            default:      led = '0;
        endcase
    end

    // Verdict once the pen is lifted
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            correct   <= 1'b0;
            incorrect <= 1'b0;
        end else if (!mouse_l && (drawn != '0)) begin
            correct   <= pass;
            incorrect <= !pass;
        end
    end

endmodule

// File: source/geodesics_pkg.sv
package geodesics_pkg;

    typedef logic [6:0]  xcoord_t;
    typedef logic [5:0]  ycoord_t;
    typedef logic [12:0] pixel_addr_t;
    typedef logic [15:0] color_t;
    typedef logic [10:0] count_t;
    typedef logic [3:0]  nibble_t;

    // Counter shown on the LEDs
    typedef enum logic [1:0] {
        SHOW_DRAWN,
        SHOW_OFF,
        SHOW_OVERLAP
    } display_sel_t;

    typedef struct packed {
        logic [5:0] ring_minor;
        logic       east;
        ycoord_t    point_high;
        ycoord_t    point_low;
    } puzzle_t;

    typedef struct packed {
        xcoord_t     x;
        ycoord_t     y;
        pixel_addr_t addr;
        logic        in_disk;
        logic        on_fixed_ring;
        logic        on_random_ring;
        logic        in_hemisphere;
        logic        marker_red;
        logic        marker_black;
        logic        on_arc;
        logic        near_cursor;
        logic        under_pen;
    } geometry_t;

    typedef struct packed {
        logic new_trace;
        logic new_overlap;
    } overlay_t;

endpackage

// File: source/geodesics_top.sv
`timescale 1ns/1ps

module geodesics_top (
    input  logic                        clock,
    input  logic                        reset,
    input  geodesics_pkg::xcoord_t      x,
    input  geodesics_pkg::ycoord_t      y,
    input  geodesics_pkg::xcoord_t      mouse_x,
    input  geodesics_pkg::ycoord_t      mouse_y,
    input  logic                        mouse_l,
    input  logic                        new_round,
    input  geodesics_pkg::display_sel_t display_sel,
    output geodesics_pkg::color_t       pixel_data,
    output geodesics_pkg::count_t       led,
    output logic                        correct,
    output logic                        incorrect,
    output logic                        ready
);
    import geodesics_pkg::*;

    puzzle_t   puzzle;
    geometry_t geometry;
    overlay_t  overlay;

    puzzle_generator generator (
        .clock     (clock),
        .reset     (reset),
        .new_round (new_round),
        .puzzle    (puzzle)
    );

    // Pipeline: geometry, trace memory, counters
    sphere_geometry stage1 (
        .clock    (clock),
        .reset    (reset),
        .x        (x),
        .y        (y),
        .mouse_x  (mouse_x),
        .mouse_y  (mouse_y),
        .mouse_l  (mouse_l),
        .puzzle   (puzzle),
        .geometry (geometry)
    );

    trace_overlay stage2 (
        .clock      (clock),
        .reset      (reset),
        .geometry   (geometry),
        .mouse_l    (mouse_l),
        .pixel_data (pixel_data),
        .overlay    (overlay),
        .ready      (ready)
    );

    answer_scorer stage3 (
        .clock       (clock),
        .reset       (reset),
        .overlay     (overlay),
        .mouse_l     (mouse_l),
        .display_sel (display_sel),
        .led         (led),
        .correct     (correct),
        .incorrect   (incorrect)
    );

endmodule

// File: source/puzzle_generator.sv
`timescale 1ns/1ps
`include "geodesics_consts.svh"

module puzzle_generator (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   new_round,
    output geodesics_pkg::puzzle_t puzzle
);
    import geodesics_pkg::*;

    localparam int RING = 0;
    localparam int SIDE = 1;
    localparam int HIGH = 2;
    localparam int LOW  = 3;

    nibble_t lfsr [4];

    //////////////////////////////
    // Four 4-bit LFSRs, XNOR feedback
    //////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lfsr[RING] <= `SEED_RING;
            lfsr[SIDE] <= `SEED_SIDE;
            lfsr[HIGH] <= `SEED_HIGH;
            lfsr[LOW]  <= `SEED_LOW;
        end else if (new_round) begin
            for (int i = 0; i < 4; i++) begin
                lfsr[i] <= {lfsr[i][2:0], ~(lfsr[i][3] ^ lfsr[i][2])};
            end
        end
    end

    // Puzzle fields from the raw values
    always_comb begin
        puzzle.ring_minor = 6'(lfsr[RING]) + 6'(`RING_BASE);
        puzzle.east       = lfsr[SIDE][0];
        puzzle.point_high = ycoord_t'(lfsr[HIGH]) + ycoord_t'(`POINT_HIGH_OFS);
        puzzle.point_low  = ycoord_t'(lfsr[LOW]) + ycoord_t'(`POINT_LOW_OFS);
    end

endmodule

// File: source/sphere_geometry.sv
`timescale 1ns/1ps
`include "geodesics_consts.svh"

module sphere_geometry (
    input  logic                     clock,
    input  logic                     reset,
    input  geodesics_pkg::xcoord_t   x,
    input  geodesics_pkg::ycoord_t   y,
    input  geodesics_pkg::xcoord_t   mouse_x,
    input  geodesics_pkg::ycoord_t   mouse_y,
    input  logic                     mouse_l,
    input  geodesics_pkg::puzzle_t   puzzle,
    output geodesics_pkg::geometry_t geometry
);
    import geodesics_pkg::*;

    logic [6:0]  dx;
    logic [6:0]  dy;
    logic [11:0] dx2;
    logic [11:0] dy2;
    logic [6:0]  dist_high;
    logic [6:0]  dist_low;
    logic [6:0]  cursor_dx;
    logic [6:0]  cursor_dy;
    logic        marker_ok;
    geometry_t   next;

    function automatic logic [6:0] abs_diff(input logic [6:0] a, input logic [6:0] b);
        return (a > b) ? a - b : b - a;
    endfunction

    // Ellipse band, rx across and ry down, widened by slack
    function automatic logic on_band(input logic [11:0] dx_sq, input logic [11:0] dy_sq,
                                     input logic [5:0] rx, input logic [5:0] ry,
                                     input logic [5:0] slack);
        logic [23:0] limit;
        logic [23:0] outer;
        logic [23:0] inner;
        limit = rx * rx * ry * ry;
        outer = (ry + slack) * (ry + slack) * dx_sq + (rx + slack) * (rx + slack) * dy_sq;
        inner = (ry - slack) * (ry - slack) * dx_sq + (rx - slack) * (rx - slack) * dy_sq;
        return (outer >= limit) && (inner <= limit);
    endfunction

    always_comb begin
        dx  = abs_diff(x, 7'(`CENTER_X));
        dy  = abs_diff({1'b0, y}, 7'(`CENTER_Y));
        dx2 = dx * dx;
        dy2 = dy * dy;

        dist_high = abs_diff({1'b0, y}, {1'b0, puzzle.point_high});
        dist_low  = abs_diff({1'b0, y}, {1'b0, puzzle.point_low});
        cursor_dx = abs_diff(x, mouse_x);
        cursor_dy = abs_diff({1'b0, y}, {1'b0, mouse_y});

        next.x    = x;
        next.y    = y;
        next.addr = pixel_addr_t'(y * `SCREEN_W + x);

        next.in_disk       = (dx2 + dy2) < (`SPHERE_R * `SPHERE_R);
        // Upright ring or the one lying flat, drawn only on the sphere
        next.on_fixed_ring = next.in_disk &&
            (on_band(dx2, dy2, 6'(`RING_MINOR), 6'(`RING_MAJOR), 6'd1) ||
             on_band(dx2, dy2, 6'(`RING_MAJOR), 6'(`RING_MINOR), 6'd1));
        next.on_random_ring = on_band(dx2, dy2, puzzle.ring_minor, 6'(`RING_MAJOR), 6'd2);
        next.in_hemisphere  = puzzle.east ? (x > 7'(`CENTER_X)) : (x < 7'(`CENTER_X));

        marker_ok = next.on_random_ring && next.in_hemisphere && (y > 6'(`MARKER_MIN_ROW));
        next.marker_red   = marker_ok && (dist_high <= 7'd1 || dist_low <= 7'd1);
        next.marker_black = marker_ok && (dist_high == 7'd2 || dist_low == 7'd2);

        // True geodesic between the two points
        next.on_arc = next.on_random_ring && next.in_hemisphere &&
                      (y >= puzzle.point_high) && (y <= puzzle.point_low);

        next.near_cursor = (cursor_dx <= 7'd1) && (cursor_dy <= 7'd1);
        // Pen covers the 2x2 block right of and below the mouse
        next.under_pen   = mouse_l && next.in_disk &&
                           (x >= mouse_x) && (cursor_dx <= 7'd1) &&
                           (y >= mouse_y) && (cursor_dy <= 7'd1);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            geometry <= '0;
        end else begin
            geometry <= next;
        end
    end

endmodule

// File: source/trace_overlay.sv
`timescale 1ns/1ps
`include "geodesics_consts.svh"

module trace_overlay (
    input  logic                     clock,
    input  logic                     reset,
    input  geodesics_pkg::geometry_t geometry,
    input  logic                     mouse_l,
    output geodesics_pkg::color_t    pixel_data,
    output geodesics_pkg::overlay_t  overlay,
    output logic                     ready
);
    import geodesics_pkg::*;

    // Bit 0 traced, bit 1 scored
    logic [1:0]  trace_mem [`PIXEL_COUNT];
    pixel_addr_t sweep_addr;
    geometry_t   geo_d;
    logic [1:0]  rd_word;
    logic        rd_live;
    logic        answered;
    logic        traced;
    logic        score;
    logic [1:0]  word_next;
    logic        write_en;
    overlay_t    overlay_next;
    color_t      color;

    //////////////////////////////
    // Clear sweep after reset
    //////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sweep_addr <= '0;
            ready      <= 1'b0;
        end else if (!ready) begin
            if (sweep_addr == pixel_addr_t'(`PIXEL_COUNT - 1)) begin
                ready <= 1'b1;
            end else begin
                sweep_addr <= sweep_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!ready) begin
            trace_mem[sweep_addr] <= 2'b00;
        end else if (write_en) begin
            trace_mem[geo_d.addr] <= word_next;
        end
    end

    // Read stage, forwarding a write to the same pixel
    always_ff @(posedge clock) begin
        geo_d <= geometry;
        if (write_en && (geometry.addr == geo_d.addr)) begin
            rd_word <= word_next;
        end else begin
            rd_word <= trace_mem[geometry.addr];
        end
    end

    //////////////////////////////
    // Trace update and color
    //////////////////////////////
    always_comb begin
        traced    = rd_word[0] | geo_d.under_pen;
        score     = traced & geo_d.on_arc & mouse_l;
        word_next = {rd_word[1] | score, traced};
        write_en  = rd_live && (word_next != rd_word);

        overlay_next.new_trace   = rd_live & geo_d.under_pen & ~rd_word[0];
        overlay_next.new_overlap = rd_live & score & ~rd_word[1];
    end

    // Later tests win
    always_comb begin
        color = `COLOR_BLACK;
        if (geo_d.in_disk) begin
            color = `COLOR_BLUE;
        end
        if (geo_d.on_fixed_ring) begin
            color = `COLOR_WHITE;
        end
        if (traced) begin
            color = `COLOR_PURPLE;
        end
        if (geo_d.marker_black) begin
            color = `COLOR_BLACK;
        end
        if (geo_d.marker_red) begin
            color = `COLOR_RED;
        end
        if (answered && !mouse_l && geo_d.on_arc) begin
            color = `COLOR_RED;
        end
        if (geo_d.near_cursor) begin
            color = `COLOR_ORANGE;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_live    <= 1'b0;
            answered   <= 1'b0;
            pixel_data <= `COLOR_BLACK;
            overlay    <= '0;
        end else begin
            // Word read now was cleared only if the sweep had already ended
            rd_live    <= ready;
            pixel_data <= rd_live ? color : `COLOR_BLACK;
            overlay    <= overlay_next;
            if (rd_live && mouse_l && geo_d.in_disk) begin
                answered <= 1'b1;
            end
        end
    end

endmodule
